/* dafx_pkg.sv */
// --------------------
// dafx shared definitions
// audio and gain words, egress states and the saturating gain helper
// --------------------

package dafx_pkg;

  localparam int AUDIO_WIDTH    = 24;
  localparam int GAIN_WIDTH     = 24;
  localparam int Q_BITS         = 11;              // 2048 is unity gain
  localparam int NR_OF_CHANNELS = 2;               // stereo pair
  localparam int ACC_WIDTH      = AUDIO_WIDTH + 8; // mix headroom

  typedef logic signed [AUDIO_WIDTH-1:0] audio_t;
  typedef logic        [GAIN_WIDTH-1:0]  gain_t;

  typedef enum logic [1:0] {
    egr_idle,
    egr_send_left,
    egr_send_right
  } egr_state_t;

  // value times gain, shifted down by q_bits, clamped to the audio range
  function automatic audio_t mul_sat(input  logic signed [ACC_WIDTH-1:0] value,
                                     input  gain_t                       gain,
                                     input  int                          q_bits,
                                     output logic                        clip);
    logic signed [ACC_WIDTH+GAIN_WIDTH:0] prod;
    logic signed [ACC_WIDTH+GAIN_WIDTH:0] lim_hi;
    logic signed [ACC_WIDTH+GAIN_WIDTH:0] lim_lo;
    lim_hi = (1 <<< (AUDIO_WIDTH - 1)) - 1; // +full scale
    lim_lo = -lim_hi - 1;                   // -full scale
    prod   = value * $signed({1'b0, gain}); // gain is unsigned
    prod   = prod >>> q_bits;
    clip   = 1'b0;
    if (prod > lim_hi) begin
      clip    = 1'b1;
      mul_sat = lim_hi[AUDIO_WIDTH-1:0];
    end else if (prod < lim_lo) begin
      clip    = 1'b1;
      mul_sat = lim_lo[AUDIO_WIDTH-1:0];
    end else begin
      mul_sat = prod[AUDIO_WIDTH-1:0];
    end
  endfunction

endpackage

/* adc_ingress.sv */
// --------------------
// adc ingress
// pairs left and right ADC words into a channel vector and meters signed peaks
// --------------------
`timescale 1ns/10ps

module adc_ingress import dafx_pkg::*; #(
  parameter int AUDIO_WIDTH = dafx_pkg::AUDIO_WIDTH
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  audio_t                        adc_data,
  input  logic                          adc_valid,
  input  logic                          adc_last,    // high on the right word
  input  logic                          clear_peaks,
  output audio_t [NR_OF_CHANNELS-1:0]   chan_data,
  output logic                          chan_valid,
  output audio_t                        peak_min,
  output audio_t                        peak_max
);

  audio_t                        adc_data_r;
  logic                          adc_valid_r;
  logic                          adc_last_r;
  logic signed [AUDIO_WIDTH-1:0] left_word;  // waits for its right partner

  // --------------------
  // input stage and pairing
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      adc_valid_r <= 1'b0;
      adc_last_r  <= 1'b0;
      chan_valid  <= 1'b0;
    end else begin
      adc_valid_r <= adc_valid;
      adc_last_r  <= adc_last;
      chan_valid  <= adc_valid_r && adc_last_r; // one pulse per frame
    end
  end

  always_ff @(posedge clk) begin
    adc_data_r <= adc_data;
    if (adc_valid_r && !adc_last_r) begin
      left_word <= adc_data_r;
    end
    if (adc_valid_r && adc_last_r) begin
      chan_data[0] <= left_word;   // left
      chan_data[1] <= adc_data_r;  // right
    end
  end

  // --------------------
  // peak meter straight off the adc port
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      peak_min <= '0;
      peak_max <= '0;
    end else if (clear_peaks) begin // clear beats a sample
      peak_min <= '0;
      peak_max <= '0;
    end else if (adc_valid) begin
      if (adc_data < peak_min) peak_min <= adc_data;
      if (adc_data > peak_max) peak_max <= adc_data;
    end
  end

endmodule

/* channel_gain.sv */
// --------------------
// channel gain
// per-channel Q gain with saturation, one register stage
// --------------------
`timescale 1ns/10ps

module channel_gain import dafx_pkg::*; #(
  parameter int NR_OF_CHANNELS = dafx_pkg::NR_OF_CHANNELS,
  parameter int Q_BITS         = dafx_pkg::Q_BITS
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  audio_t [NR_OF_CHANNELS-1:0] chan_data,
  input  logic                        chan_valid,
  input  gain_t  [NR_OF_CHANNELS-1:0] ch_gain,
  output audio_t [NR_OF_CHANNELS-1:0] gained_data,
  output logic                        gained_valid,
  output logic   [NR_OF_CHANNELS-1:0] chan_clip    // one per channel
);

  audio_t [NR_OF_CHANNELS-1:0] gain_res;
  logic   [NR_OF_CHANNELS-1:0] gain_clip;

  always_comb begin
    for (int i = 0; i < NR_OF_CHANNELS; i++) begin
      gain_res[i] = mul_sat(chan_data[i], ch_gain[i], Q_BITS, gain_clip[i]);
    end
  end

  // clip only counts on a real sample
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gained_valid <= 1'b0;
      chan_clip    <= '0;
    end else begin
      gained_valid <= chan_valid;
      chan_clip    <= chan_valid ? gain_clip : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (chan_valid) begin
      gained_data <= gain_res;
    end
  end

endmodule

/* mix_bus.sv */
// --------------------
// mix bus
// pan routing, stereo sum and saturating output gain
// --------------------
`timescale 1ns/10ps

module mix_bus import dafx_pkg::*; #(
  parameter int NR_OF_CHANNELS = dafx_pkg::NR_OF_CHANNELS,
  parameter int Q_BITS         = dafx_pkg::Q_BITS
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  audio_t [NR_OF_CHANNELS-1:0] gained_data,
  input  logic                        gained_valid,
  input  logic   [NR_OF_CHANNELS-1:0] ch_pan,       // 0 left, 1 right
  input  gain_t                       out_gain,
  output audio_t                      mix_left,
  output audio_t                      mix_right,
  output logic                        mix_valid,
  output logic                        out_clip
);

  logic signed [ACC_WIDTH-1:0] sum_left;
  logic signed [ACC_WIDTH-1:0] sum_right;
  audio_t                      left_next;
  audio_t                      right_next;
  logic                        clip_left;
  logic                        clip_right;

  // --------------------
  // routing and sum
  // --------------------
  always_comb begin
    sum_left  = '0;
    sum_right = '0;
    for (int i = 0; i < NR_OF_CHANNELS; i++) begin
      if (ch_pan[i]) begin
        sum_right = sum_right + gained_data[i];
      end else begin
        sum_left  = sum_left + gained_data[i];
      end
    end
    left_next  = mul_sat(sum_left,  out_gain, Q_BITS, clip_left);  // master gain
    right_next = mul_sat(sum_right, out_gain, Q_BITS, clip_right);
  end

  // --------------------
  // output register
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mix_valid <= 1'b0;
      out_clip  <= 1'b0;
    end else begin
      mix_valid <= gained_valid;
      out_clip  <= gained_valid && (clip_left || clip_right); // either side
    end
  end

  always_ff @(posedge clk) begin
    if (gained_valid) begin
      mix_left  <= left_next;
      mix_right <= right_next;
    end
  end

endmodule

/* dac_egress.sv */
// --------------------
// dac egress
// serializes a mixed pair into left then right DAC words
// --------------------
`timescale 1ns/10ps

module dac_egress import dafx_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  audio_t mix_left,
  input  audio_t mix_right,
  input  logic   mix_valid,
  output audio_t dac_data,
  output logic   dac_valid,
  output logic   dac_last,
  input  logic   dac_ready
);

  egr_state_t egr_state;
  audio_t     right_hold; // right word parked while left goes out

  // --------------------
  // state machine
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      egr_state <= egr_idle;
      dac_valid <= 1'b0;
      dac_last  <= 1'b0;
    end else begin
      case (egr_state)
        egr_idle: begin
          if (mix_valid) begin // pairs arriving when busy are lost
            egr_state <= egr_send_left;
            dac_valid <= 1'b1;
            dac_last  <= 1'b0;
          end
        end
        egr_send_left: begin
          if (dac_ready) begin
            egr_state <= egr_send_right;
            dac_last  <= 1'b1;
          end
        end
        egr_send_right: begin
          if (dac_ready) begin
            egr_state <= egr_idle;
            dac_valid <= 1'b0;
            dac_last  <= 1'b0;
          end
        end
        default: egr_state <= egr_idle;
      endcase
    end
  end

  // data path holds under back-pressure
  always_ff @(posedge clk) begin
    if (egr_state == egr_idle && mix_valid) begin
      right_hold <= mix_right;
      dac_data   <= mix_left;
    end else if (egr_state == egr_send_left && dac_ready) begin
      dac_data <= right_hold;
    end
  end

endmodule

/* clip_indicator.sv */
// --------------------
// clip indicator
// holds a blinking LED for a while after any clip
// --------------------
`timescale 1ns/10ps

module clip_indicator #(
  parameter int CLIP_HOLD_CYCLES = 64,
  parameter int BLINK_BIT        = 3
) (
  input  logic clk,
  input  logic rst_n,
  input  logic clip,
  output logic clip_led
);

  // wide enough for the hold count and the blink bit
  localparam int CNT_WIDTH = ($clog2(CLIP_HOLD_CYCLES) > BLINK_BIT) ?
                             $clog2(CLIP_HOLD_CYCLES) : BLINK_BIT + 1;

  logic                 hold;
  logic [CNT_WIDTH-1:0] hold_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold     <= 1'b0;
      hold_cnt <= '0;
      clip_led <= 1'b0;
    end else begin
      clip_led <= hold && hold_cnt[BLINK_BIT]; // blink rate
      if (clip) begin               // restart on every clip
        hold     <= 1'b1;
        hold_cnt <= '0;
      end else if (hold) begin
        if (hold_cnt == CNT_WIDTH'(CLIP_HOLD_CYCLES - 1)) begin
          hold     <= 1'b0;
          hold_cnt <= '0;
        end else begin
          hold_cnt <= hold_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* tick_generator.sv */
// --------------------
// tick generator
// two periodic interrupt pulses and a heartbeat toggle
// --------------------
`timescale 1ns/10ps

module tick_generator #(
  parameter int IRQ0_PERIOD      = 100,
  parameter int IRQ1_PERIOD      = 37,
  parameter int HEARTBEAT_PERIOD = 50
) (
  input  logic clk,
  input  logic rst_n,
  output logic irq_0,
  output logic irq_1,
  output logic heartbeat_led
);

  // index 0 irq_0, 1 irq_1, 2 heartbeat
  localparam logic [2:0][31:0] PERIODS = {32'(HEARTBEAT_PERIOD),
                                          32'(IRQ1_PERIOD),
                                          32'(IRQ0_PERIOD)};
  localparam int MAX_PERIOD = (IRQ0_PERIOD > IRQ1_PERIOD) ?
                              ((IRQ0_PERIOD > HEARTBEAT_PERIOD) ? IRQ0_PERIOD : HEARTBEAT_PERIOD) :
                              ((IRQ1_PERIOD > HEARTBEAT_PERIOD) ? IRQ1_PERIOD : HEARTBEAT_PERIOD);
  localparam int CNT_WIDTH  = $clog2(MAX_PERIOD);

  logic [2:0] wrap;

  for (genvar i = 0; i < 3; i++) begin : g_tick
    logic [CNT_WIDTH-1:0] cnt;
    assign wrap[i] = (cnt == CNT_WIDTH'(PERIODS[i] - 1)); // last count of period
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)       cnt <= '0;
      else if (wrap[i]) cnt <= '0;
      else              cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_0         <= 1'b0;
      irq_1         <= 1'b0;
      heartbeat_led <= 1'b0;
    end else begin
      irq_0 <= wrap[0]; // single-cycle pulses
      irq_1 <= wrap[1];
      if (wrap[2]) heartbeat_led <= ~heartbeat_led;
    end
  end

endmodule

/* dafx_core.sv */
// --------------------
// dafx core
// stereo audio path ADC to DAC with gain, pan, mix, meter and clip LED
// --------------------
`timescale 1ns/10ps

module dafx_core import dafx_pkg::*; #(
  parameter int AUDIO_WIDTH      = dafx_pkg::AUDIO_WIDTH,
  parameter int NR_OF_CHANNELS   = dafx_pkg::NR_OF_CHANNELS,
  parameter int Q_BITS           = dafx_pkg::Q_BITS,
  parameter int CLIP_HOLD_CYCLES = 64,
  parameter int BLINK_BIT        = 3,
  parameter int IRQ0_PERIOD      = 100,
  parameter int IRQ1_PERIOD      = 37,
  parameter int HEARTBEAT_PERIOD = 50
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // codec side
  input  audio_t                      adc_data,
  input  logic                        adc_valid,
  input  logic                        adc_last,
  output audio_t                      dac_data,
  output logic                        dac_valid,
  output logic                        dac_last,
  input  logic                        dac_ready,
  // control
  input  gain_t  [NR_OF_CHANNELS-1:0] ch_gain,
  input  logic   [NR_OF_CHANNELS-1:0] ch_pan,
  input  gain_t                       out_gain,
  input  logic                        clear_peaks,
  // status
  output audio_t                      peak_min,
  output audio_t                      peak_max,
  output logic                        clip_led,
  output logic                        irq_0,
  output logic                        irq_1,
  output logic                        heartbeat_led
);

  audio_t [NR_OF_CHANNELS-1:0] chan_data;
  logic                        chan_valid;
  audio_t [NR_OF_CHANNELS-1:0] gained_data;
  logic                        gained_valid;
  logic   [NR_OF_CHANNELS-1:0] chan_clip;
  audio_t                      mix_left;
  audio_t                      mix_right;
  logic                        mix_valid;
  logic                        out_clip;
  logic                        any_clip;

  assign any_clip = (|chan_clip) || out_clip; // channel or master

  // --------------------
  // audio path
  // --------------------
  adc_ingress #(
    .AUDIO_WIDTH (AUDIO_WIDTH)
  ) adc_ingress_i0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .adc_data    (adc_data),
    .adc_valid   (adc_valid),
    .adc_last    (adc_last),
    .clear_peaks (clear_peaks),
    .chan_data   (chan_data),
    .chan_valid  (chan_valid),
    .peak_min    (peak_min),
    .peak_max    (peak_max)
  );

  channel_gain #(
    .NR_OF_CHANNELS (NR_OF_CHANNELS),
    .Q_BITS         (Q_BITS)
  ) channel_gain_i0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .chan_data    (chan_data),
    .chan_valid   (chan_valid),
    .ch_gain      (ch_gain),
    .gained_data  (gained_data),
    .gained_valid (gained_valid),
    .chan_clip    (chan_clip)
  );

  mix_bus #(
    .NR_OF_CHANNELS (NR_OF_CHANNELS),
    .Q_BITS         (Q_BITS)
  ) mix_bus_i0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .gained_data  (gained_data),
    .gained_valid (gained_valid),
    .ch_pan       (ch_pan),
    .out_gain     (out_gain),
    .mix_left     (mix_left),
    .mix_right    (mix_right),
    .mix_valid    (mix_valid),
    .out_clip     (out_clip)
  );

  dac_egress dac_egress_i0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .mix_left  (mix_left),
    .mix_right (mix_right),
    .mix_valid (mix_valid),
    .dac_data  (dac_data),
    .dac_valid (dac_valid),
    .dac_last  (dac_last),
    .dac_ready (dac_ready)
  );

  // --------------------
  // status outputs
  // --------------------
  clip_indicator #(
    .CLIP_HOLD_CYCLES (CLIP_HOLD_CYCLES),
    .BLINK_BIT        (BLINK_BIT)
  ) clip_indicator_i0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .clip     (any_clip),
    .clip_led (clip_led)
  );

  tick_generator #(
    .IRQ0_PERIOD      (IRQ0_PERIOD),
    .IRQ1_PERIOD      (IRQ1_PERIOD),
    .HEARTBEAT_PERIOD (HEARTBEAT_PERIOD)
  ) tick_generator_i0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_0         (irq_0),
    .irq_1         (irq_1),
    .heartbeat_led (heartbeat_led)
  );

endmodule

/* dafx_core_chk.sv */
// --------------------
// dafx core protocol checker
// DAC handshake and tick pulse rules bound into the core
// --------------------
`timescale 1ns/10ps

module dafx_core_chk import dafx_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input audio_t dac_data,
  input logic   dac_valid,
  input logic   dac_last,
  input logic   dac_ready,
  input logic   irq_0
);

  int fail_cnt = 0; // failed assertions so far

  // word holds under back-pressure
  property p_dac_hold;
    @(posedge clk) disable iff (!rst_n)
      (dac_valid && !dac_ready) |=> (dac_valid && $stable(dac_data) && $stable(dac_last));
  endproperty

  // one-cycle pulse only
  property p_irq0_single;
    @(posedge clk) disable iff (!rst_n) irq_0 |=> !irq_0;
  endproperty

  property p_last_in_valid;
    @(posedge clk) disable iff (!rst_n) dac_last |-> dac_valid;
  endproperty

  a_dac_hold: assert property (p_dac_hold) else begin
    $error("dac word changed under back-pressure");
    fail_cnt++;
  end

  a_irq0_single: assert property (p_irq0_single) else begin
    $error("irq_0 high two cycles in a row");
    fail_cnt++;
  end

  a_last_in_valid: assert property (p_last_in_valid) else begin
    $error("dac_last high without dac_valid");
    fail_cnt++;
  end

endmodule

bind dafx_core dafx_core_chk chk0 (
  .clk       (clk),
  .rst_n     (rst_n),
  .dac_data  (dac_data),
  .dac_valid (dac_valid),
  .dac_last  (dac_last),
  .dac_ready (dac_ready),
  .irq_0     (irq_0)
);

/* tb_dafx_core.sv */
// --------------------
// dafx core testbench
// file driven frames, DAC pair checks, peaks, clip LED and ticks
// --------------------
`timescale 1ns/10ps

module tb_dafx_core;

  localparam int MAX_VEC          = 32;
  localparam int CLIP_HOLD_CYCLES = 64;
  localparam int BLINK_BIT        = 3;
  localparam int IRQ0_PERIOD      = 100;
  localparam int IRQ1_PERIOD      = 37;
  localparam int HEARTBEAT_PERIOD = 50;

  logic              clk;
  logic              rst_n;
  logic [23:0]       adc_data;
  logic              adc_valid;
  logic              adc_last;
  logic              dac_ready;
  logic [1:0][23:0]  ch_gain;
  logic [1:0]        ch_pan;
  logic [23:0]       out_gain;
  logic              clear_peaks;
  logic [23:0]       dac_data;
  logic              dac_valid;
  logic              dac_last;
  logic [23:0]       peak_min;
  logic [23:0]       peak_max;
  logic              clip_led;
  logic              irq_0;
  logic              irq_1;
  logic              heartbeat_led;

  // vectors from the data file
  logic [23:0] v_left [MAX_VEC];
  logic [23:0] v_right[MAX_VEC];
  logic [23:0] v_g0   [MAX_VEC];
  logic [23:0] v_g1   [MAX_VEC];
  logic [23:0] v_pan  [MAX_VEC];
  logic [23:0] v_og   [MAX_VEC];
  logic [23:0] v_exp_l[MAX_VEC];
  logic [23:0] v_exp_r[MAX_VEC];
  logic [23:0] v_clip [MAX_VEC];
  int          n_vec;

  logic [24:0]        acc_q[$];      // {last, data} per accepted word
  logic signed [23:0] mdl_min;       // expected peaks
  logic signed [23:0] mdl_max;
  int   cyc;                         // edges since time 0
  int   tick_cnt;                    // edges since reset release
  int   limit;
  int   accepted;
  int   frames_sent;
  int   data_errors;
  int   timing_errors;
  int   chk_errors;
  int   seed;
  bit   ready_force;                 // holds dac_ready high
  bit   led_watch;                   // clip_led must stay low

  dafx_core dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .adc_data      (adc_data),
    .adc_valid     (adc_valid),
    .adc_last      (adc_last),
    .dac_data      (dac_data),
    .dac_valid     (dac_valid),
    .dac_last      (dac_last),
    .dac_ready     (dac_ready),
    .ch_gain       (ch_gain),
    .ch_pan        (ch_pan),
    .out_gain      (out_gain),
    .clear_peaks   (clear_peaks),
    .peak_min      (peak_min),
    .peak_max      (peak_max),
    .clip_led      (clip_led),
    .irq_0         (irq_0),
    .irq_1         (irq_1),
    .heartbeat_led (heartbeat_led)
  );

  always #4 clk = ~clk; // 8 ns

  // --------------------
  // counters, timeout, ready and monitors
  // --------------------
  always @(posedge clk) begin
    logic [31:0] rnd;
    cyc <= cyc + 1;
    if (rst_n) tick_cnt <= tick_cnt + 1;
    rnd = $random(seed);
    dac_ready <= rst_n && (ready_force || rnd[0]);       // random back-pressure
    if (rst_n && dac_valid && dac_ready) begin             // handshake taken
      acc_q.push_back({dac_last, dac_data});
      accepted <= accepted + 1;
    end
    if (cyc >= limit) begin
      $display("timeout: no finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (tick_cnt > 0) begin
      assert (irq_0 == (tick_cnt % IRQ0_PERIOD == 0)) else begin
        timing_errors++;
        $display("** Error at %0t: irq_0 expected %0b, got %0b", $time,
                 tick_cnt % IRQ0_PERIOD == 0, irq_0);
      end
      assert (irq_1 == (tick_cnt % IRQ1_PERIOD == 0)) else begin
        timing_errors++;
        $display("** Error at %0t: irq_1 expected %0b, got %0b", $time,
                 tick_cnt % IRQ1_PERIOD == 0, irq_1);
      end
      assert (heartbeat_led == ((tick_cnt / HEARTBEAT_PERIOD) % 2 == 1)) else begin
        timing_errors++;
        $display("** Error at %0t: heartbeat_led expected %0b, got %0b", $time,
                 (tick_cnt / HEARTBEAT_PERIOD) % 2 == 1, heartbeat_led);
      end
    end
    if (led_watch) begin
      assert (clip_led == 1'b0) else begin
        timing_errors++;
        $display("** Error at %0t: clip_led expected 0, got %0b", $time, clip_led);
      end
    end
  end

  // --------------------
  // helpers
  // --------------------
  task automatic check_value(input string name, input logic [23:0] exp, input logic [23:0] got);
    assert (exp === got) else begin
      data_errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic track_peak(input logic signed [23:0] w);
    if (w < mdl_min) mdl_min = w;
    if (w > mdl_max) mdl_max = w;
  endtask

  // sends left then right and returns the edge that samples the right word
  task automatic send_frame(input int i, input bit clr, output int s_cyc);
    @(posedge clk);
    adc_data    <= v_left[i];
    adc_valid   <= 1'b1;
    adc_last    <= 1'b0;
    clear_peaks <= clr;
    ch_gain[0]  <= v_g0[i];
    ch_gain[1]  <= v_g1[i];
    ch_pan      <= v_pan[i][1:0];
    out_gain    <= v_og[i];
    if (clr) begin   // clear wins over the left word
      mdl_min = '0;
      mdl_max = '0;
    end else begin
      track_peak(v_left[i]);
    end
    @(posedge clk);
    adc_data    <= v_right[i];
    adc_last    <= 1'b1;
    clear_peaks <= 1'b0;
    track_peak(v_right[i]);
    @(posedge clk);
    adc_valid <= 1'b0;
    adc_last  <= 1'b0;
    s_cyc = cyc + 1;
    frames_sent++;
  endtask

  task automatic check_peaks();
    @(negedge clk);
    check_value("peak_min", mdl_min, peak_min);
    check_value("peak_max", mdl_max, peak_max);
  endtask

  task automatic collect_pair(input int i);
    logic [24:0] w;
    while (acc_q.size() < 2) @(negedge clk);
    w = acc_q.pop_front();
    check_value("dac_last (left)", 24'(0), 24'(w[24]));
    check_value("dac_data (left)", v_exp_l[i], w[23:0]);
    w = acc_q.pop_front();
    check_value("dac_last (right)", 24'(1), 24'(w[24]));
    check_value("dac_data (right)", v_exp_r[i], w[23:0]);
  endtask

  task automatic read_vectors();
    int    fd;
    int    n;
    string line;
    fd = $fopen("dafx_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open dafx_testdata.txt for reading");
    end else begin
      while ($fgets(line, fd) > 0 && n_vec < MAX_VEC) begin
        if (line.len() < 2 || line[0] == 8'h23) continue; // comment or blank
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v_left[n_vec], v_right[n_vec],
                    v_g0[n_vec], v_g1[n_vec], v_pan[n_vec], v_og[n_vec],
                    v_exp_l[n_vec], v_exp_r[n_vec], v_clip[n_vec]);
        if (n == 9) n_vec++;
      end
      $fclose(fd);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  task automatic run_tests();
    int s;
    int rise_lim;
    int clip_idx;
    int quiet;
    for (int i = 0; i < n_vec; i++) begin
      if (i == 5) begin  // standalone clear pulse
        @(posedge clk);
        clear_peaks <= 1'b1;
        @(posedge clk);
        clear_peaks <= 1'b0;
        mdl_min = '0;
        mdl_max = '0;
        check_peaks();
      end
      send_frame(i, i == 6, s);  // vector 6 also clears with its left word
      check_peaks();
      if (i == 0) begin
        while (!dac_valid) @(negedge clk);
        assert (cyc - s == 4) else begin
          timing_errors++;
          $display("** Error at %0t: dac_valid latency expected 4, got %0d", $time, cyc - s);
        end
      end
      collect_pair(i);
      ready_force = 1'b0;
      repeat (6) @(posedge clk);
    end

    // clip LED from idle to blink and back
    repeat (CLIP_HOLD_CYCLES + 16) @(posedge clk);
    @(negedge clk);
    ready_force = 1'b1;
    assert (clip_led == 1'b0) else begin
      timing_errors++;
      $display("clip_led still lit long after the last clip");
    end
    clip_idx = -1;
    for (int i = n_vec - 1; i >= 0; i--) begin
      if (v_clip[i] != '0) clip_idx = i;  // earliest clipping vector
    end
    if (clip_idx < 0) begin
      data_errors++;
      $display("data file holds no clipping vector");
    end else begin
      send_frame(clip_idx, 1'b0, s);
      rise_lim = 3 + (1 << BLINK_BIT) + 2;  // pipeline to flag then blink bit
      @(negedge clk);
      while (!clip_led && (cyc - s) < rise_lim) @(negedge clk);
      assert (clip_led == 1'b1) else begin
        timing_errors++;
        $display("clip_led did not light within %0d cycles of a clipping frame", rise_lim);
      end
      collect_pair(clip_idx);
      repeat (CLIP_HOLD_CYCLES) @(negedge clk);
    end
    led_watch   = 1'b1;  // hold over before the non-clipping run
    ready_force = 1'b0;
    quiet       = 0;
    for (int i = 0; i < n_vec && quiet < 4; i++) begin
      if (v_clip[i] == '0) begin
        send_frame(i, 1'b0, s);
        check_peaks();
        collect_pair(i);
        repeat (6) @(posedge clk);
        quiet++;
      end
    end
    led_watch = 1'b0;

    assert (accepted == 2 * frames_sent) else begin
      data_errors++;
      $display("** Error at %0t: accepted words expected %0d, got %0d", $time,
               2 * frames_sent, accepted);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    clk           = 0;
    rst_n         = 0;
    adc_data      = '0;
    adc_valid     = 0;
    adc_last      = 0;
    dac_ready     = 0;
    ch_gain       = '0;
    ch_pan        = '0;
    out_gain      = '0;
    clear_peaks   = 0;
    cyc           = 0;
    tick_cnt      = 0;
    accepted      = 0;
    frames_sent   = 0;
    n_vec         = 0;
    data_errors   = 0;
    timing_errors = 0;
    chk_errors    = 0;
    seed          = 52;
    limit         = 500;
    ready_force   = 1'b1;  // first vector sees no back-pressure
    led_watch     = 1'b0;
    mdl_min       = '0;
    mdl_max       = '0;
    read_vectors();
    limit = 40 * (n_vec + 5) + 500 + CLIP_HOLD_CYCLES * 2;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    if (n_vec < 4) begin
      data_errors++;
      $display("data file holds only %0d vectors", n_vec);
    end else begin
      run_tests();
    end

    chk_errors = dut0.chk0.fail_cnt;
    $display("errors: data %0d, timing %0d, protocol %0d, total %0d", data_errors,
             timing_errors, chk_errors, data_errors + timing_errors + chk_errors);
    if (data_errors + timing_errors + chk_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* dafx_testdata.txt */
# left right gain0 gain1 pan out_gain exp_left exp_right exp_clip, all hex
# pan bit0 routes channel 0, bit1 channel 1 (0 left, 1 right), 800 is unity gain
000100 000200 000800 000800 2 000800 000100 000200 0
000100 000200 000800 000800 1 000800 000200 000100 0
001000 fff000 000400 000400 2 000800 000800 fff800 0
000300 000500 000800 000800 0 000800 000800 000000 0
fffe00 000100 000800 000800 3 000800 000000 ffff00 0
002000 004000 000800 000800 2 000400 001000 002000 0
400000 c00000 001000 001000 2 000800 7fffff 800000 1
600000 000000 000800 000800 0 001000 7fffff 000000 1
500000 500000 000800 000800 0 000800 7fffff 000000 1
a00000 a00000 000800 000800 3 000800 000000 800000 1
000010 fffff0 000800 000800 2 000800 000010 fffff0 0
012345 fedcba 000800 000800 2 000800 012345 fedcba 0
7fffff 800000 000800 000800 2 000800 7fffff 800000 0
000000 000001 000800 000800 1 000800 000001 000000 0

/* tb.f */
dafx_pkg.sv
adc_ingress.sv
channel_gain.sv
mix_bus.sv
dac_egress.sv
clip_indicator.sv
tick_generator.sv
dafx_core.sv
dafx_core_chk.sv
tb_dafx_core.sv

/* run.sh */
#!/bin/sh
# build and run the dafx core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dafx_core -f tb.f -o sim_dafx

./obj_dir/sim_dafx > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation ok"
